// ==== filelist.f ====
+incdir+include
hdl/fetch_pkg.sv
hdl/pc_select.sv
hdl/prefetch_buffer.sv
hdl/instr_aligner.sv
hdl/compressed_decoder.sv
hdl/if_id_register.sv
hdl/fetch_stage.sv
sim/tb_clock_gen.sv
sim/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_stage

sources:
  - include_dirs:
      - include
    files:
      - hdl/fetch_pkg.sv
      - hdl/pc_select.sv
      - hdl/prefetch_buffer.sv
      - hdl/instr_aligner.sv
      - hdl/compressed_decoder.sv
      - hdl/if_id_register.sv
      - hdl/fetch_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/tb_clock_gen.sv
      - sim/fetch_tb.sv

// ==== sim/fetch_tb.sv ====
// Testbench for the fetch stage with a random-latency memory and a reference PC
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetch_tb;
        localparam int N_ITEMS = 180;
        logic                   clk;
        logic                   arst_n;
        logic                   req;
        logic                   gnt;
        logic                   rvalid;
        logic                   id_ready;
        logic                   halt;
        logic                   clear;
        logic [31:0]            rdata;
        logic [31:0]            instr_addr;
        logic [31:0]            exp_addr;
        logic [31:0]            ref_pc;
        logic                   instr_req;
        logic                   valid_id;
        logic                   busy;
        fetch_pkg::pc_ctrl_t    pc_ctrl;
        fetch_pkg::instr_item_t item_id;
        fetch_pkg::instr_item_t exp;
        logic [31:0]            table_q [256];
        logic [31:0]            gnt_q [$];
        integer                 seed = 32'h5d810947;
        int                     errors = 0;
        int                     accepted = 0;
        int                     gnt_wait = 0;
        int                     resp_wait = 0;

        tb_clock_gen u_clk (.clk(clk), .arst_n_o(arst_n));

        fetch_stage u_dut (
                .clk                 (clk),
                .arst_n_i            (arst_n),
                .req_i               (req),
                .pc_ctrl_i           (pc_ctrl),
                .instr_gnt_i         (gnt),
                .instr_rvalid_i      (rvalid),
                .instr_rdata_i       (rdata),
                .id_ready_i          (id_ready),
                .halt_if_i           (halt),
                .clear_instr_valid_i (clear),
                .instr_req_o         (instr_req),
                .instr_addr_o        (instr_addr),
                .instr_valid_id_o    (valid_id),
                .item_id_o           (item_id),
                .if_busy_o           (busy)
        );

        function automatic logic [15:0] half_at(input logic [31:0] a);
                logic [31:0] w;
                w = table_q[a[9:2]];
                return a[1] ? w[31:16] : w[15:0];
        endfunction

        // Reference expansion written from the RVC field layout
        function automatic fetch_pkg::instr_item_t expect_item(input logic [31:0] pc);
                fetch_pkg::instr_item_t it;
                logic [15:0] h;
                logic [11:0] imm;
                logic [20:0] off;
                h = half_at(pc);
                imm = {{7{h[12]}}, h[6:2]};
                off = {{10{h[12]}}, h[8], h[10:9], h[6], h[7], h[2], h[11], h[5:3], 1'b0};
                it.pc = pc;
                it.is_compressed = (h[1:0] != 2'b11);
                it.illegal_c = 1'b0;
                if (!it.is_compressed)
                        it.instr = {half_at(pc + 32'd2), h};
                else if (h[15:13] == 3'b000 && h[1:0] == 2'b01)
                        it.instr = {imm, h[11:7], 3'b000, h[11:7], 7'h13};
                else if (h[15:13] == 3'b010 && h[1:0] == 2'b01)
                        it.instr = {imm, 5'd0, 3'b000, h[11:7], 7'h13};
                else if (h[15:13] == 3'b101 && h[1:0] == 2'b01)
                        it.instr = {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'h6f};
                else begin
                        it.instr = {16'h0000, h};
                        it.illegal_c = 1'b1;
                end
                return it;
        endfunction

        function automatic logic [31:0] redirect_target(input fetch_pkg::pc_ctrl_t c);
                logic [31:0] t;
                case (c.pc_mux)
                        fetch_pkg::PC_JUMP:      t = c.jump_target;
                        fetch_pkg::PC_EXCEPTION: t = {c.trap_base, 8'h00} + {c.exc_vec, 2'b00};
                        fetch_pkg::PC_MRET:      t = c.mepc;
                        default:                 t = `FETCH_BOOT_ADDR;
                endcase
                return t & ~32'd1;
        endfunction

        // ----------------------------------------------------------------------
        // Checking and memory model bookkeeping at the rising edge
        // ----------------------------------------------------------------------
        always @(posedge clk) begin
                if (arst_n) begin
                        assert (busy == (gnt_q.size() != 0)) else begin
                                errors++;
                                $display("Error at %0t: if_busy_o expected %b got %b",
                                         $time, gnt_q.size() != 0, busy);
                        end
                        if (rvalid)
                                void'(gnt_q.pop_front());
                        if (pc_ctrl.pc_set) begin
                                ref_pc = redirect_target(pc_ctrl);
                                exp_addr = ref_pc & ~32'd3;
                        end else if (instr_req && gnt) begin
                                assert (instr_addr == exp_addr) else begin
                                        errors++;
                                        $display("Error at %0t: instr_addr_o expected %h got %h",
                                                 $time, exp_addr, instr_addr);
                                end
                                exp_addr = exp_addr + 32'd4;
                        end
                        if (instr_req && gnt)
                                gnt_q.push_back(instr_addr);
                        assert (gnt_q.size() <= `FETCH_BUF_DEPTH) else begin
                                errors++;
                                $display("Error at %0t: more requests outstanding than allowed",
                                         $time);
                        end
                        if (valid_id && id_ready && !halt && !clear && !pc_ctrl.pc_set) begin
                                exp = expect_item(ref_pc);
                                assert (item_id == exp) else begin
                                        errors++;
                                        $display("Error at %0t: item_id_o expected %h got %h",
                                                 $time, exp, item_id);
                                end
                                ref_pc = ref_pc + (exp.is_compressed ? 32'd2 : 32'd4);
                                accepted++;
                        end
                end
        end

        // Held item under back-pressure, and clear takes effect on the next edge
        assert property (@(posedge clk) disable iff (!arst_n)
                (valid_id && !id_ready && !clear) |=> (valid_id && $stable(item_id)))
                else begin
                        errors++;
                        $display("Error at %0t: item changed while decode was not ready", $time);
                end
        assert property (@(posedge clk) disable iff (!arst_n) clear |=> !valid_id)
                else begin
                        errors++;
                        $display("Error at %0t: instr_valid_id_o stayed high after clear", $time);
                end

        // Memory model and ready driven on the falling edge
        always @(negedge clk) begin
                id_ready = ($unsigned($random(seed)) % 4) != 0;
                if (gnt_wait != 0) begin
                        gnt = 1'b0;
                        gnt_wait--;
                end else begin
                        gnt = 1'b1;
                        gnt_wait = $unsigned($random(seed)) % 4;
                end
                if (resp_wait != 0 || gnt_q.size() == 0) begin
                        rvalid = 1'b0;
                        if (resp_wait != 0)
                                resp_wait--;
                end else begin
                        rvalid = 1'b1;
                        rdata = table_q[gnt_q[0][9:2]];
                        resp_wait = $unsigned($random(seed)) % 4;
                end
        end

        task automatic run_items(input int n);
                int goal;
                goal = accepted + n;
                while (accepted < goal)
                        @(negedge clk);
        endtask

        task automatic redirect(input fetch_pkg::pc_mux_e mux, input logic [31:0] addr);
                pc_ctrl.pc_mux = mux;
                pc_ctrl.jump_target = addr;
                pc_ctrl.mepc = addr;
                pc_ctrl.pc_set = 1'b1;
                clear = 1'b1;
                @(negedge clk);
                pc_ctrl.pc_set = 1'b0;
                clear = 1'b0;
        endtask

        initial begin
                #(40 * N_ITEMS * 40);
                $display("Watchdog expired before all instructions were accepted");
                $display("SIMULATION FAILED");
                $finish;
        end

        initial begin
                // Fetch is requested already while reset is applied
                req = 1'b1;
                gnt = 1'b0;
                rvalid = 1'b0;
                rdata = '0;
                id_ready = 1'b0;
                halt = 1'b0;
                clear = 1'b0;
                pc_ctrl = '0;
                ref_pc = `FETCH_BOOT_ADDR;
                exp_addr = `FETCH_BOOT_ADDR;
                for (int i = 0; i < 256; i++)
                        table_q[i] = $random(seed) ^ (i << 2);
                // Boot code with 32-bit addi, C.LI, C.ADDI, C.J, straddling addi and illegal
                table_q[32] = 32'h0050_0093;
                table_q[33] = 32'h10fd_4095;
                table_q[34] = 32'h0093_a001;
                table_q[35] = 32'h0000_0050;
                pc_ctrl.trap_base = 24'h000001;
                pc_ctrl.exc_vec = 5'd7;
                repeat (5) @(negedge clk);
                assert (!instr_req && !valid_id) else begin
                        errors++;
                        $display("Error at %0t: request or valid high during reset", $time);
                end
                @(posedge arst_n);
                @(negedge clk);
                run_items(60);
                redirect(fetch_pkg::PC_JUMP, 32'h0000_01a2);
                run_items(40);
                redirect(fetch_pkg::PC_EXCEPTION, 32'h0);
                run_items(40);
                redirect(fetch_pkg::PC_MRET, 32'h0000_02a7);
                run_items(40);
                $display("Run complete: %0d errors, %0d items accepted", errors, accepted);
                if (errors == 0) begin
                        $display("SIMULATION PASSED");
                end else begin
                        $display("SIMULATION FAILED");
                end
                $finish;
        end

endmodule

// ==== sim/tb_clock_gen.sv ====
// Testbench clock and reset generator, 40 ns period with a 10-cycle reset
`timescale 1ns/1ns

module tb_clock_gen (
        output logic clk,
        output logic arst_n_o
);
        localparam int PERIOD = 40;

        initial begin
                clk      = 1'b0;
                arst_n_o = 1'b0;
                repeat (10) @(posedge clk);
                @(negedge clk);
                arst_n_o = 1'b1;
        end

        always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== hdl/fetch_stage.sv ====
// Instruction fetch stage top, chains pc select, prefetch, align, expand, register
`timescale 1ns/1ns
`include "fetch_config.svh"

module fetch_stage (
        input  logic                     clk,
        input  logic                     arst_n_i,
        input  logic                     req_i,
        input  fetch_pkg::pc_ctrl_t      pc_ctrl_i,
        input  logic                     instr_gnt_i,
        input  logic                     instr_rvalid_i,
        input  logic [`FETCH_ADDR_W-1:0] instr_rdata_i,
        input  logic                     id_ready_i,
        input  logic                     halt_if_i,
        input  logic                     clear_instr_valid_i,
        output logic                     instr_req_o,
        output logic [`FETCH_ADDR_W-1:0] instr_addr_o,
        output logic                     instr_valid_id_o,
        output fetch_pkg::instr_item_t   item_id_o,
        output logic                     if_busy_o
);
        logic                     branch;
        logic [`FETCH_ADDR_W-1:0] branch_addr;
        logic                     fetch_valid;
        logic                     fetch_ready;
        fetch_pkg::fetch_word_u   fetch_rdata;
        logic                     instr_valid;
        logic [`FETCH_ADDR_W-1:0] instr_aligned;
        logic [`FETCH_ADDR_W-1:0] pc_if;
        fetch_pkg::instr_item_t   item;
        logic                     item_ready;

        pc_select u_pc_select (
                .pc_ctrl       (pc_ctrl_i),
                .branch_o      (branch),
                .branch_addr_o (branch_addr)
        );

        prefetch_buffer u_prefetch_buffer (
                .clk            (clk),
                .arst_n_i       (arst_n_i),
                .req_i          (req_i),
                .branch_i       (branch),
                .branch_addr_i  (branch_addr),
                .instr_gnt_i    (instr_gnt_i),
                .instr_rvalid_i (instr_rvalid_i),
                .instr_rdata_i  (instr_rdata_i),
                .fetch_ready_i  (fetch_ready),
                .instr_req_o    (instr_req_o),
                .instr_addr_o   (instr_addr_o),
                .fetch_valid_o  (fetch_valid),
                .fetch_rdata_o  (fetch_rdata),
                .busy_o         (if_busy_o)
        );

        instr_aligner u_instr_aligner (
                .clk           (clk),
                .arst_n_i      (arst_n_i),
                .fetch_valid_i (fetch_valid),
                .fetch_rdata_i (fetch_rdata),
                .branch_i      (branch),
                .branch_addr_i (branch_addr),
                .out_ready_i   (item_ready),
                .fetch_ready_o (fetch_ready),
                .instr_valid_o (instr_valid),
                .instr_o       (instr_aligned),
                .pc_o          (pc_if)
        );

        compressed_decoder u_compressed_decoder (
                .instr_i (instr_aligned),
                .pc_i    (pc_if),
                .item_o  (item)
        );

        if_id_register u_if_id_register (
                .clk                 (clk),
                .arst_n_i            (arst_n_i),
                .item_valid_i        (instr_valid),
                .item_i              (item),
                .id_ready_i          (id_ready_i),
                .halt_if_i           (halt_if_i),
                .clear_instr_valid_i (clear_instr_valid_i),
                .item_ready_o        (item_ready),
                .instr_valid_id_o    (instr_valid_id_o),
                .item_id_o           (item_id_o)
        );

endmodule

// ==== hdl/if_id_register.sv ====
// IF/ID pipeline register, holds the item for decode under back-pressure
`timescale 1ns/1ns

module if_id_register (
        input  logic                   clk,
        input  logic                   arst_n_i,
        input  logic                   item_valid_i,
        input  fetch_pkg::instr_item_t item_i,
        input  logic                   id_ready_i,
        input  logic                   halt_if_i,
        input  logic                   clear_instr_valid_i,
        output logic                   item_ready_o,
        output logic                   instr_valid_id_o,
        output fetch_pkg::instr_item_t item_id_o
);
        // A clear stalls the aligner so no fetched item is lost
        assign item_ready_o = id_ready_i & ~halt_if_i & ~clear_instr_valid_i;

        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        instr_valid_id_o <= 1'b0;
                end else if (clear_instr_valid_i) begin
                        instr_valid_id_o <= 1'b0;
                end else if (item_ready_o) begin
                        instr_valid_id_o <= item_valid_i;
                end
        end

        always_ff @(posedge clk) begin
                if (item_ready_o && item_valid_i) begin
                        item_id_o <= item_i;
                end
        end

endmodule

// ==== hdl/compressed_decoder.sv ====
// Compressed decoder, expands C.ADDI, C.LI and C.J and flags the rest
`timescale 1ns/1ns
`include "fetch_config.svh"

module compressed_decoder (
        input  logic [`FETCH_ADDR_W-1:0] instr_i,
        input  logic [`FETCH_ADDR_W-1:0] pc_i,
        output fetch_pkg::instr_item_t   item_o
);
        logic        is_c;
        logic [11:0] imm6;
        logic [20:1] j_off;

        assign is_c = (instr_i[1:0] != 2'b11);

        // CI-format immediate, sign extended to twelve bits
        assign imm6 = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2]};

        // CJ-format offset, scrambled bit order of the RVC spec
        assign j_off = {{9{instr_i[12]}}, instr_i[12], instr_i[8], instr_i[10:9],
                        instr_i[6], instr_i[7], instr_i[2], instr_i[11], instr_i[5:3]};

        always_comb begin
                item_o.pc            = pc_i;
                item_o.is_compressed = is_c;
                item_o.illegal_c     = 1'b0;
                item_o.instr         = instr_i;
                if (is_c) begin
                        unique case ({instr_i[15:13], instr_i[1:0]})
                                // C.ADDI rd, rd, imm
                                5'b000_01: begin
                                        item_o.instr = {imm6, instr_i[11:7], 3'b000,
                                                        instr_i[11:7], `FETCH_OPC_OPIMM};
                                end
                                // C.LI, addi from x0
                                5'b010_01: begin
                                        item_o.instr = {imm6, 5'd0, 3'b000,
                                                        instr_i[11:7], `FETCH_OPC_OPIMM};
                                end
                                // C.J, jal with rd x0
                                5'b101_01: begin
                                        item_o.instr = {j_off[20], j_off[10:1], j_off[11],
                                                        j_off[19:12], 5'd0, `FETCH_OPC_JAL};
                                end
                                default: begin
                                        item_o.instr     = {16'h0000, instr_i[15:0]};
                                        item_o.illegal_c = 1'b1;
                                end
                        endcase
                end
        end

endmodule

// ==== hdl/instr_aligner.sv ====
// Instruction aligner, cuts the word stream into 16 and 32 bit instructions
`timescale 1ns/1ns
`include "fetch_config.svh"

module instr_aligner (
        input  logic                     clk,
        input  logic                     arst_n_i,
        input  logic                     fetch_valid_i,
        input  fetch_pkg::fetch_word_u   fetch_rdata_i,
        input  logic                     branch_i,
        input  logic [`FETCH_ADDR_W-1:0] branch_addr_i,
        input  logic                     out_ready_i,
        output logic                     fetch_ready_o,
        output logic                     instr_valid_o,
        output logic [`FETCH_ADDR_W-1:0] instr_o,
        output logic [`FETCH_ADDR_W-1:0] pc_o
);
        logic [`FETCH_ADDR_W-1:0] pc_q;
        logic                     half_q;
        logic [15:0]              hi_q;
        logic                     lo_c;
        logic                     hi_c;
        logic                     is_c;
        logic                     accept;
        logic                     save_hi;

        // Compressed when the low two bits are not both set
        assign lo_c = (fetch_rdata_i.half.lo[1:0] != 2'b11);
        assign hi_c = (fetch_rdata_i.half.hi[1:0] != 2'b11);

        // half_q marks a saved upper half waiting for the next word
        always_comb begin
                instr_o       = fetch_rdata_i.word;
                instr_valid_o = 1'b0;
                fetch_ready_o = 1'b0;
                is_c          = 1'b0;
                if (half_q) begin
                        // Straddling word, the upper half stays for later
                        instr_o       = {fetch_rdata_i.half.lo, hi_q};
                        instr_valid_o = fetch_valid_i;
                end else if (pc_q[1]) begin
                        if (hi_c) begin
                                instr_o       = {16'h0000, fetch_rdata_i.half.hi};
                                instr_valid_o = fetch_valid_i;
                                fetch_ready_o = out_ready_i;
                                is_c          = 1'b1;
                        end else begin
                                fetch_ready_o = 1'b1;
                        end
                end else if (lo_c) begin
                        instr_o       = {16'h0000, fetch_rdata_i.half.lo};
                        instr_valid_o = fetch_valid_i;
                        is_c          = 1'b1;
                end else begin
                        instr_valid_o = fetch_valid_i;
                        fetch_ready_o = out_ready_i;
                end
                // Nothing from the old path leaves during a redirect
                if (branch_i) begin
                        instr_valid_o = 1'b0;
                end
        end

        assign accept  = instr_valid_o & out_ready_i;
        assign save_hi = ~branch_i & ~half_q & pc_q[1] & fetch_valid_i & ~hi_c;
        assign pc_o    = pc_q;

        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        pc_q   <= `FETCH_BOOT_ADDR;
                        half_q <= 1'b0;
                end else if (branch_i) begin
                        // Bit 1 set skips the low half of the first word
                        pc_q   <= branch_addr_i;
                        half_q <= 1'b0;
                end else if (accept) begin
                        pc_q   <= pc_q + (is_c ? `FETCH_ADDR_W'(2) : `FETCH_ADDR_W'(4));
                        half_q <= 1'b0;
                end else if (save_hi) begin
                        half_q <= 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (save_hi) begin
                        hi_q <= fetch_rdata_i.half.hi;
                end
        end

endmodule

// ==== hdl/prefetch_buffer.sv ====
// Prefetch buffer that issues word fetches and queues the returned words
`timescale 1ns/1ns
`include "fetch_config.svh"

module prefetch_buffer (
        input  logic                     clk,
        input  logic                     arst_n_i,
        input  logic                     req_i,
        input  logic                     branch_i,
        input  logic [`FETCH_ADDR_W-1:0] branch_addr_i,
        input  logic                     instr_gnt_i,
        input  logic                     instr_rvalid_i,
        input  logic [`FETCH_ADDR_W-1:0] instr_rdata_i,
        input  logic                     fetch_ready_i,
        output logic                     instr_req_o,
        output logic [`FETCH_ADDR_W-1:0] instr_addr_o,
        output logic                     fetch_valid_o,
        output fetch_pkg::fetch_word_u   fetch_rdata_o,
        output logic                     busy_o
);
        localparam int DEPTH = `FETCH_BUF_DEPTH;
        localparam int CNT_W = $clog2(DEPTH + 1);
        localparam int PTR_W = $clog2(DEPTH);

        logic [`FETCH_ADDR_W-1:0] fetch_addr_q;
        logic [CNT_W-1:0]         outstanding_q;
        logic [CNT_W-1:0]         drop_q;
        logic [CNT_W-1:0]         count_q;
        logic [PTR_W-1:0]         wr_ptr_q;
        logic [PTR_W-1:0]         rd_ptr_q;
        fetch_pkg::fetch_word_u   mem_q [DEPTH];
        logic                     fetch_en_q;
        logic                     gnt_fire;
        logic                     resp_drop;
        logic                     push;
        logic                     pop;

        // -------------------------------------------------------------------
        // Memory port where in-flight plus queued words never exceed the depth
        // -------------------------------------------------------------------
        assign instr_req_o = req_i && fetch_en_q &&
                (int'(outstanding_q) + int'(drop_q) + int'(count_q) < DEPTH);
        assign instr_addr_o = fetch_addr_q;
        assign gnt_fire     = instr_req_o & instr_gnt_i;

        // Responses owed to a flushed path are consumed first
        assign resp_drop = instr_rvalid_i & (drop_q != '0);
        assign push      = instr_rvalid_i & ~resp_drop & ~branch_i;
        assign pop       = fetch_valid_o & fetch_ready_i & ~branch_i;

        assign fetch_valid_o = (count_q != '0);
        assign fetch_rdata_o = mem_q[rd_ptr_q];
        assign busy_o        = (outstanding_q != '0) || (drop_q != '0);

        // Requests stay low while reset is applied
        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        fetch_en_q <= 1'b0;
                end else begin
                        fetch_en_q <= 1'b1;
                end
        end

        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        fetch_addr_q  <= `FETCH_BOOT_ADDR;
                        outstanding_q <= '0;
                        drop_q        <= '0;
                        count_q       <= '0;
                        wr_ptr_q      <= '0;
                        rd_ptr_q      <= '0;
                end else if (branch_i) begin
                        // Everything in flight now belongs to the old path
                        fetch_addr_q  <= {branch_addr_i[`FETCH_ADDR_W-1:2], 2'b00};
                        outstanding_q <= '0;
                        drop_q        <= drop_q + outstanding_q + CNT_W'(gnt_fire)
                                         - CNT_W'(instr_rvalid_i);
                        count_q       <= '0;
                        wr_ptr_q      <= '0;
                        rd_ptr_q      <= '0;
                end else begin
                        if (gnt_fire) begin
                                fetch_addr_q <= fetch_addr_q + `FETCH_ADDR_W'(4);
                        end
                        outstanding_q <= outstanding_q + CNT_W'(gnt_fire) - CNT_W'(push);
                        drop_q        <= drop_q - CNT_W'(resp_drop);
                        count_q       <= count_q + CNT_W'(push) - CNT_W'(pop);
                        if (push) begin
                                wr_ptr_q <= wr_ptr_q + PTR_W'(1);
                        end
                        if (pop) begin
                                rd_ptr_q <= rd_ptr_q + PTR_W'(1);
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (push) begin
                        mem_q[wr_ptr_q] <= instr_rdata_i;
                end
        end

endmodule

// ==== hdl/pc_select.sv ====
// Next-PC selection, turns the controller request into a redirect target
`timescale 1ns/1ns
`include "fetch_config.svh"

module pc_select (
        input  fetch_pkg::pc_ctrl_t      pc_ctrl,
        output logic                     branch_o,
        output logic [`FETCH_ADDR_W-1:0] branch_addr_o
);
        logic [`FETCH_ADDR_W-1:0] target;

        always_comb begin
                unique case (pc_ctrl.pc_mux)
                        fetch_pkg::PC_BOOT: begin
                                target = `FETCH_BOOT_ADDR;
                        end
                        fetch_pkg::PC_JUMP: begin
                                target = pc_ctrl.jump_target;
                        end
                        fetch_pkg::PC_EXCEPTION: begin
                                // Vectored entry, one word slot per cause
                                target = {pc_ctrl.trap_base, 1'b0, pc_ctrl.exc_vec, 2'b00};
                        end
                        fetch_pkg::PC_MRET: begin
                                target = pc_ctrl.mepc;
                        end
                        default: begin
                                target = `FETCH_BOOT_ADDR;
                        end
                endcase
        end

        // Instructions are at least halfword aligned
        assign branch_addr_o = {target[`FETCH_ADDR_W-1:1], 1'b0};
        assign branch_o      = pc_ctrl.pc_set;

endmodule

// ==== hdl/fetch_pkg.sv ====
// Shared types of the instruction fetch stage
`include "fetch_config.svh"

package fetch_pkg;

        typedef enum logic [1:0] {
                PC_BOOT      = 2'd0,
                PC_JUMP      = 2'd1,
                PC_EXCEPTION = 2'd2,
                PC_MRET      = 2'd3
        } pc_mux_e;

        // Redirect request coming from the controller
        typedef struct packed {
                logic                          pc_set;
                pc_mux_e                       pc_mux;
                logic [`FETCH_VEC_W-1:0]       exc_vec;
                logic [`FETCH_TRAP_BASE_W-1:0] trap_base;
                logic [`FETCH_ADDR_W-1:0]      jump_target;
                logic [`FETCH_ADDR_W-1:0]      mepc;
        } pc_ctrl_t;

        typedef struct packed {
                logic [15:0] hi;
                logic [15:0] lo;
        } half_pair_t;

        // A fetched word, read whole or as two halfwords
        typedef union packed {
                logic [`FETCH_ADDR_W-1:0] word;
                half_pair_t               half;
        } fetch_word_u;

        // Instruction handed towards the decode stage
        typedef struct packed {
                logic [`FETCH_ADDR_W-1:0] instr;
                logic [`FETCH_ADDR_W-1:0] pc;
                logic                     is_compressed;
                logic                     illegal_c;
        } instr_item_t;

endpackage

// ==== include/fetch_config.svh ====
// Fetch stage configuration: widths, boot address, buffer depth and opcodes
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// Address and instruction word width
`define FETCH_ADDR_W 32

// First fetch address after reset
`define FETCH_BOOT_ADDR 32'h0000_0080

// Prefetch entries, also the limit on outstanding requests
`define FETCH_BUF_DEPTH 2

// Exception vector index and trap base widths
`define FETCH_VEC_W 5
`define FETCH_TRAP_BASE_W 24

// Base opcodes produced by the compressed expansion
`define FETCH_OPC_OPIMM 7'b0010011
`define FETCH_OPC_JAL 7'b1101111

`endif
